//--- hw/gb_link_defs.svh
// Width, transfer index, palette and backup sector macros for the dual console glue
`ifndef GB_LINK_DEFS_SVH
`define GB_LINK_DEFS_SVH

////////////////////
// Widths
////////////////////

// Host transfer channel
`define GB_IDX_W        8
`define GB_XFER_ADDR_W  25
`define GB_WORD_W       16

// Sector interface
`define GB_LBA_W        32
`define GB_BUF_ADDR_W   8

// Per-player data
`define GB_SAMPLE_W     16
`define GB_PAL_W        128

// Four 24-bit colors followed by padding
`define GB_PAL_RESET    128'h828214517356305A5F1A3B4900000000

////////////////////
// Transfer indices
////////////////////

`define GB_IDX_CART_GB   8'h01
`define GB_IDX_CART_GBC  8'h41
`define GB_IDX_CART_ALT  8'h80
`define GB_IDX_PALETTE   8'h03
`define GB_IDX_BIOS      8'h40

////////////////////
// Backup RAM
////////////////////

// Sectors 0x000 to 0x0FF belong to player 1, the rest to player 2
`define GB_BK_LAST_SECTOR  9'h1FF
`define GB_BK_PLAYER_BIT   8

`endif

//--- hw/gb_host_pkg.sv
// Host transfer, sector request and sector buffer types
`default_nettype none
`include "gb_link_defs.svh"

package gb_host_pkg;

	// Index of the file that the host is transferring
	typedef logic [`GB_IDX_W-1:0] xfer_idx_t;

	// Transfer and sector buffer word
	typedef logic [`GB_WORD_W-1:0] xfer_word_t;

	typedef logic [`GB_LBA_W-1:0] sector_t;

	// Word address inside one 512-byte sector
	typedef logic [`GB_BUF_ADDR_W-1:0] buf_addr_t;

	// One beat of a host download
	typedef struct packed {
		logic                       download;
		logic                       wr;
		logic [`GB_XFER_ADDR_W-1:0] addr;
		xfer_word_t                 data;
	} xfer_beat_t;

	// Level requests toward the host, held until acknowledge rises
	typedef struct packed {
		sector_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	// Host side of the sector buffer
	typedef struct packed {
		logic       ack;
		logic       wr;
		buf_addr_t  addr;
		xfer_word_t data;
	} sd_buf_t;

endpackage

`default_nettype wire

//--- hw/gb_player_pkg.sv
// Per-player joypad, audio, palette and backup port types with the mode enums
`default_nettype none
`include "gb_link_defs.svh"

package gb_player_pkg;

	// Host joystick word, bit 0 right, 1 left, 2 down, 3 up, 4..7 buttons
	typedef logic [15:0] joystick_t;

	// Column value read by the console, active low
	typedef logic [3:0] joy_nibble_t;

	// Select lines P14 and P15 written by the console
	typedef logic [1:0] joy_sel_t;

	typedef logic [`GB_SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef logic [`GB_PAL_W-1:0] palette_t;

	// Backup RAM port of one cartridge
	typedef struct packed {
		logic [16:0]           addr;
		logic                  wr;
		logic [`GB_WORD_W-1:0] data;
	} bk_port_t;

	typedef enum logic [1:0] {
		AUDIO_P1,
		AUDIO_P2,
		AUDIO_MIX,
		AUDIO_SPLIT
	} audio_mode_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_t;

endpackage

`default_nettype wire

//--- hw/download_palette.sv
// Download index decoder and custom palette shift register
`default_nettype none
`include "gb_link_defs.svh"

module download_palette (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gb_host_pkg::xfer_beat_t  xfer,
	input  gb_host_pkg::xfer_idx_t   xfer_index,
	output logic                     cart_download,
	output logic                     bios_download,
	output gb_player_pkg::palette_t  palette
);

	import gb_host_pkg::*;

	logic       palette_download;
	xfer_word_t swapped;

	////////////////////
	// Transfer classes
	////////////////////

	// Three cartridge types share the same ROM path
	assign cart_download = xfer.download &
		((xfer_index == `GB_IDX_CART_GB) |
		 (xfer_index == `GB_IDX_CART_GBC) |
		 (xfer_index == `GB_IDX_CART_ALT));

	assign bios_download = xfer.download & (xfer_index == `GB_IDX_BIOS);

	assign palette_download = xfer.download & (xfer_index == `GB_IDX_PALETTE);

	////////////////////
	// Palette
	////////////////////

	// Palette files are stored big endian
	assign swapped = {xfer.data[7:0], xfer.data[15:8]};

	// New words enter at the bottom, the first word ends up on top
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= `GB_PAL_RESET;
		end else if (palette_download & xfer.wr) begin
			palette <= {palette[`GB_PAL_W-`GB_WORD_W-1:0], swapped};
		end
	end

endmodule

`default_nettype wire

//--- hw/joypad_matrix.sv
// Joypad matrix for both players, joystick word to column nibble
`default_nettype none

module joypad_matrix (
	input  gb_player_pkg::joystick_t   joy1,
	input  gb_player_pkg::joystick_t   joy2,
	input  gb_player_pkg::joy_sel_t    sel1,
	input  gb_player_pkg::joy_sel_t    sel2,
	output gb_player_pkg::joy_nibble_t col1,
	output gb_player_pkg::joy_nibble_t col2
);

	import gb_player_pkg::*;

	// A pressed key pulls its column low only while its group is selected
	function automatic joy_nibble_t matrix_col(input joystick_t joy, input joy_sel_t sel);
		joy_nibble_t dir;
		joy_nibble_t btn;
		// Down, up, left, right
		dir = ~{joy[2], joy[3], joy[1], joy[0]} | {4{sel[0]}};
		// Start, select, B, A
		btn = ~joy[7:4] | {4{sel[1]}};
		return dir & btn;
	endfunction

	assign col1 = matrix_col(joy1, sel1);
	assign col2 = matrix_col(joy2, sel2);

endmodule

`default_nettype wire

//--- hw/audio_select.sv
// Stereo output selection and mixing of the two console cores
`default_nettype none

module audio_select (
	input  gb_player_pkg::audio_mode_t mode,
	input  gb_player_pkg::stereo_t     core1,
	input  gb_player_pkg::stereo_t     core2,
	output gb_player_pkg::stereo_t     mix
);

	import gb_player_pkg::*;

	// Halving keeps the sum of two samples in range
	function automatic sample_t half(input sample_t s);
		return s >> 1;
	endfunction

	always_comb begin
		case (mode)
			AUDIO_P1: begin
				mix = core1;
			end
			AUDIO_P2: begin
				mix = core2;
			end
			AUDIO_MIX: begin
				mix.left  = half(core1.left) + half(core2.left);
				mix.right = half(core1.right) + half(core2.right);
			end
			AUDIO_SPLIT: begin
				// Player 1 folded to mono on the left, player 2 on the right
				mix.left  = half(core1.left) + half(core1.right);
				mix.right = half(core2.left) + half(core2.right);
			end
			default: begin
				mix = core1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/backup_sequencer.sv
// Backup RAM load and save sequencer with pending tracking and player bank routing
`default_nettype none
`include "gb_link_defs.svh"

module backup_sequencer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cart_download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic [63:0]              img_size,
	input  logic                     has_save,
	input  logic [1:0]               cram_wr,
	input  logic                     osd_open,
	input  logic                     autosave,
	input  logic                     load_req,
	input  logic                     save_req,
	input  gb_host_pkg::sd_buf_t     sd_buf,
	input  gb_host_pkg::xfer_word_t  bk_q1,
	input  gb_host_pkg::xfer_word_t  bk_q2,
	output gb_host_pkg::sd_req_t     sd_req,
	output gb_host_pkg::xfer_word_t  sd_buf_din,
	output gb_player_pkg::bk_port_t  bk1,
	output gb_player_pkg::bk_port_t  bk2,
	output logic                     busy,
	output logic                     loading,
	output logic                     pending,
	output logic                     save_ok
);

	import gb_player_pkg::*;

	bk_state_t state;
	logic      save_ena;
	logic      new_load;
	logic      dl_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      start_q;
	logic      start_load_q;
	logic      dl_rise;
	logic      dl_fall;
	logic      eff_load;
	logic      eff_save;
	logic      auto_start;
	logic      req_start;
	logic      player;
	bk_port_t  bank;

	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = dl_q & ~cart_download;

	assign save_ok  = save_ena & has_save;
	assign eff_load = load_req | new_load;
	assign eff_save = save_req | (pending & osd_open & autosave);

	// Save file is mounted by the host once the cartridge is in
	assign auto_start = dl_fall & (|img_size) & save_ena;
	assign req_start  = save_ok & ((eff_load & ~load_q) | (eff_save & ~save_q));

	////////////////////
	// Flags and edges
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q         <= 1'b0;
			load_q       <= 1'b0;
			save_q       <= 1'b0;
			ack_q        <= 1'b0;
			save_ena     <= 1'b0;
			new_load     <= 1'b0;
			pending      <= 1'b0;
			start_q      <= 1'b0;
			start_load_q <= 1'b0;
		end else begin
			dl_q   <= cart_download;
			load_q <= eff_load;
			save_q <= eff_save;
			ack_q  <= sd_buf.ack;

			if (cart_download & img_mounted & ~img_readonly)
				save_ena <= 1'b1;
			else if (dl_rise)
				save_ena <= 1'b0;

			if (dl_fall & save_ok)
				new_load <= 1'b1;
			else if (busy)
				new_load <= 1'b0;

			// Unsaved cartridge RAM writes since the last transfer
			if (busy)
				pending <= 1'b0;
			else if ((|cram_wr) & ~osd_open & save_ok)
				pending <= 1'b1;

			start_q      <= (state == BK_IDLE) & (req_start | auto_start);
			start_load_q <= auto_start | eff_load;
		end
	end

	////////////////////
	// Sector FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= BK_IDLE;
			busy    <= 1'b0;
			loading <= 1'b0;
			sd_req  <= '0;
		end else begin
			// Host has taken the request
			if (~ack_q & sd_buf.ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (start_q) begin
						state      <= start_load_q ? BK_LOAD : BK_SAVE;
						busy       <= 1'b1;
						loading    <= start_load_q;
						sd_req.lba <= '0;
						sd_req.rd  <= start_load_q;
						sd_req.wr  <= ~start_load_q;
					end
				end
				BK_LOAD, BK_SAVE: begin
					// Sector done when acknowledge falls
					if (ack_q & ~sd_buf.ack) begin
						if (sd_req.lba[`GB_BK_PLAYER_BIT:0] == `GB_BK_LAST_SECTOR) begin
							state   <= BK_IDLE;
							busy    <= 1'b0;
							loading <= 1'b0;
						end else begin
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= (state == BK_LOAD);
							sd_req.wr  <= (state == BK_SAVE);
						end
					end
				end
				default: begin
					state <= BK_IDLE;
					busy  <= 1'b0;
				end
			endcase
		end
	end

	////////////////////
	// Bank routing
	////////////////////

	assign player = sd_req.lba[`GB_BK_PLAYER_BIT];

	assign bank.addr = {1'b0, sd_req.lba[`GB_BK_PLAYER_BIT-1:0], sd_buf.addr};
	assign bank.wr   = sd_buf.wr & sd_buf.ack;
	assign bank.data = sd_buf.data;

	always_comb begin
		bk1    = bank;
		bk2    = bank;
		bk1.wr = bank.wr & ~player;
		bk2.wr = bank.wr & player;
	end

	assign sd_buf_din = player ? bk_q2 : bk_q1;

endmodule

`default_nettype wire

//--- hw/dual_gb_glue.sv
// Top level of the two-player glue, download, joypad, audio and backup blocks
`default_nettype none

module dual_gb_glue (
	input  logic                        clk_sys,
	input  logic                        reset,
	// Host download
	input  gb_host_pkg::xfer_beat_t     xfer,
	input  gb_host_pkg::xfer_idx_t      xfer_index,
	output logic                        bios_download,
	output gb_player_pkg::palette_t     palette,
	// Host sector interface
	input  gb_host_pkg::sd_buf_t        sd_buf,
	output gb_host_pkg::sd_req_t        sd_req,
	output gb_host_pkg::xfer_word_t     sd_buf_din,
	input  logic                        img_mounted,
	input  logic                        img_readonly,
	input  logic [63:0]                 img_size,
	// Menu and cartridge state
	input  logic                        has_save,
	input  logic                        osd_open,
	input  logic                        autosave,
	input  logic                        load_req,
	input  logic                        save_req,
	input  logic [1:0]                  cram_wr,
	// Backup RAM ports of both cartridges
	input  gb_host_pkg::xfer_word_t     bk_q1,
	input  gb_host_pkg::xfer_word_t     bk_q2,
	output gb_player_pkg::bk_port_t     bk1,
	output gb_player_pkg::bk_port_t     bk2,
	output logic                        busy,
	output logic                        loading,
	output logic                        pending,
	output logic                        save_ok,
	// Joypads
	input  gb_player_pkg::joystick_t    joy1,
	input  gb_player_pkg::joystick_t    joy2,
	input  gb_player_pkg::joy_sel_t     sel1,
	input  gb_player_pkg::joy_sel_t     sel2,
	output gb_player_pkg::joy_nibble_t  col1,
	output gb_player_pkg::joy_nibble_t  col2,
	// Audio
	input  gb_player_pkg::audio_mode_t  audio_mode,
	input  gb_player_pkg::stereo_t      core1_audio,
	input  gb_player_pkg::stereo_t      core2_audio,
	output gb_player_pkg::stereo_t      audio
);

	logic cart_download;

	download_palette u_download (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.xfer          (xfer),
		.xfer_index    (xfer_index),
		.cart_download (cart_download),
		.bios_download (bios_download),
		.palette       (palette)
	);

	joypad_matrix u_joypad (
		.joy1 (joy1),
		.joy2 (joy2),
		.sel1 (sel1),
		.sel2 (sel2),
		.col1 (col1),
		.col2 (col2)
	);

	audio_select u_audio (
		.mode  (audio_mode),
		.core1 (core1_audio),
		.core2 (core2_audio),
		.mix   (audio)
	);

	// Cartridge download edges drive save-enable and the automatic load
	backup_sequencer u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.has_save      (has_save),
		.cram_wr       (cram_wr),
		.osd_open      (osd_open),
		.autosave      (autosave),
		.load_req      (load_req),
		.save_req      (save_req),
		.sd_buf        (sd_buf),
		.bk_q1         (bk_q1),
		.bk_q2         (bk_q2),
		.sd_req        (sd_req),
		.sd_buf_din    (sd_buf_din),
		.bk1           (bk1),
		.bk2           (bk2),
		.busy          (busy),
		.loading       (loading),
		.pending       (pending),
		.save_ok       (save_ok)
	);

endmodule

`default_nettype wire

//--- testbench/dual_gb_glue_assert.sv
// Concurrent assertions on the backup sequencer handshake, state and bank ports
`default_nettype none

module dual_gb_glue_assert (
	input logic                     clk_sys,
	input logic                     reset,
	input gb_host_pkg::sd_req_t     sd_req,
	input gb_player_pkg::bk_state_t state,
	input logic                     busy,
	input gb_player_pkg::bk_port_t  bk1,
	input gb_player_pkg::bk_port_t  bk2
);

	import gb_player_pkg::*;

	logic req;

	assign req = sd_req.rd | sd_req.wr;

	// One transfer direction at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr))
		else $error("Read and write requests are high together");

	// Host latches the sector number while the request is up
	lba_stable: assert property (@(posedge clk_sys) disable iff (reset)
		req |=> (!req || $stable(sd_req.lba)))
		else $error("Sector number changed during an open request");

	idle_not_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(state == BK_IDLE) |-> !busy)
		else $error("Busy is high while the sequencer is idle");

	// Host writes land in one bank and only while loading
	one_bank_write: assert property (@(posedge clk_sys) disable iff (reset)
		(bk1.wr || bk2.wr) |-> ((state == BK_LOAD) && !(bk1.wr && bk2.wr)))
		else $error("Backup write outside a load or to both players in one cycle");

endmodule

bind backup_sequencer dual_gb_glue_assert u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sd_req  (sd_req),
	.state   (state),
	.busy    (busy),
	.bk1     (bk1),
	.bk2     (bk2)
);

`default_nettype wire

//--- testbench/dual_gb_glue_tb.sv
// Testbench for the dual console glue with host sector model, compare tasks and watchdog
`default_nettype none
`include "gb_link_defs.svh"

module dual_gb_glue_tb;

	import gb_host_pkg::*;
	import gb_player_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int PAL_ROWS      = 12;
	localparam int JOY_ROWS      = 8;
	localparam int AUD_ROWS      = 8;
	localparam int ACK_DELAY     = 3;
	localparam int SECTOR_CYCLES = ACK_DELAY + 256 + 3;
	// Load and save each move 512 sectors
	localparam int WATCHDOG_CYCLES =
		2 * (2 * PAL_ROWS + JOY_ROWS + AUD_ROWS + 2 * 512 * SECTOR_CYCLES);

	////////////////////
	// Tables
	////////////////////

	// Transfer index, word, expected bios_download
	localparam logic [24:0] PAL_TAB [PAL_ROWS] = '{
		{`GB_IDX_PALETTE,  16'h1F2E, 1'b0},
		{`GB_IDX_PALETTE,  16'h3D4C, 1'b0},
		{`GB_IDX_CART_GB,  16'h0123, 1'b0},
		{`GB_IDX_PALETTE,  16'h5B6A, 1'b0},
		{`GB_IDX_PALETTE,  16'h7988, 1'b0},
		{`GB_IDX_BIOS,     16'h4567, 1'b1},
		{`GB_IDX_PALETTE,  16'h97A6, 1'b0},
		{`GB_IDX_PALETTE,  16'hB5C4, 1'b0},
		{`GB_IDX_CART_ALT, 16'h89AB, 1'b0},
		{`GB_IDX_PALETTE,  16'hD3E2, 1'b0},
		{`GB_IDX_CART_GBC, 16'hCDEF, 1'b0},
		{`GB_IDX_PALETTE,  16'hF100, 1'b0}
	};

	// Select lines of player 1 in the upper pair, player 2 in the lower
	localparam logic [3:0] JOY_TAB [JOY_ROWS] = '{
		4'b0000, 4'b0101, 4'b1010, 4'b1111, 4'b0110, 4'b1001, 4'b0011, 4'b1100
	};

	localparam audio_mode_t AUD_TAB [AUD_ROWS] = '{
		AUDIO_P1, AUDIO_P2, AUDIO_MIX, AUDIO_SPLIT,
		AUDIO_MIX, AUDIO_SPLIT, AUDIO_P2, AUDIO_P1
	};

	logic        clk_sys;
	logic        reset;
	xfer_beat_t  xfer;
	xfer_idx_t   xfer_index;
	logic        bios_download;
	palette_t    palette;
	sd_buf_t     sd_buf;
	sd_req_t     sd_req;
	xfer_word_t  sd_buf_din;
	logic        img_mounted;
	logic        img_readonly;
	logic [63:0] img_size;
	logic        has_save;
	logic        osd_open;
	logic        autosave;
	logic        load_req;
	logic        save_req;
	logic [1:0]  cram_wr;
	xfer_word_t  bk_q1;
	xfer_word_t  bk_q2;
	bk_port_t    bk1;
	bk_port_t    bk2;
	logic        busy;
	logic        loading;
	logic        pending;
	logic        save_ok;
	joystick_t   joy1;
	joystick_t   joy2;
	joy_sel_t    sel1;
	joy_sel_t    sel2;
	joy_nibble_t col1;
	joy_nibble_t col2;
	audio_mode_t audio_mode;
	stereo_t     core1_audio;
	stereo_t     core2_audio;
	stereo_t     audio;

	logic [15:0] lfsr = 16'd26721;
	logic        expect_read;
	sector_t     expect_lba;

	dual_gb_glue uut (.*);

	////////////////////
	// Helpers
	////////////////////

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1);
	endtask

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		int          k;
		val = '0;
		for (k = 0; k < n; k++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return val;
	endfunction

	// Backup RAM contents of each player
	function automatic xfer_word_t mem_word(input logic player, input logic [16:0] addr);
		return {addr[7:0], addr[15:8]} ^ {15'd0, addr[16]} ^ (player ? 16'hC3A5 : 16'h5A3C);
	endfunction

	function automatic joy_nibble_t joypad_expect(input joystick_t joy, input joy_sel_t sel);
		joy_nibble_t dir_key;
		joy_nibble_t col;
		int          c;
		dir_key = {joy[2], joy[3], joy[1], joy[0]};
		for (c = 0; c < 4; c++)
			col[c] = !((!sel[0] && dir_key[c]) || (!sel[1] && joy[4 + c]));
		return col;
	endfunction

	function automatic stereo_t audio_expect(input audio_mode_t m, input stereo_t c1,
			input stereo_t c2);
		stereo_t r;
		case (m)
			AUDIO_P1: begin
				r = c1;
			end
			AUDIO_P2: begin
				r = c2;
			end
			AUDIO_MIX: begin
				r.left  = c1.left / 16'd2 + c2.left / 16'd2;
				r.right = c1.right / 16'd2 + c2.right / 16'd2;
			end
			default: begin
				r.left  = c1.left / 16'd2 + c1.right / 16'd2;
				r.right = c2.left / 16'd2 + c2.right / 16'd2;
			end
		endcase
		return r;
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_palette(input string name, input palette_t exp, input palette_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_nibble(input string name, input joy_nibble_t exp,
			input joy_nibble_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_stereo(input string name, input stereo_t exp, input stereo_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_sector(input string name, input sector_t exp, input sector_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bank(input string name, input bk_port_t exp, input bk_port_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_word(input string name, input xfer_word_t exp, input xfer_word_t act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	////////////////////
	// Host sector model
	////////////////////

	task automatic serve_sector();
		logic        is_read;
		sector_t     lba;
		logic [16:0] full;
		bk_port_t    exp_bank;
		xfer_word_t  word;
		int          a;
		is_read = sd_req.rd;
		lba     = sd_req.lba;
		check_bit("request direction", expect_read, is_read);
		check_sector("request sector", expect_lba, lba);
		repeat (ACK_DELAY) tick();
		sd_buf.ack = 1'b1;
		for (a = 0; a < 256; a++) begin
			tick();
			full        = (17'(lba[7:0]) << 8) | 17'(a);
			word        = xfer_word_t'(random_bits(16));
			sd_buf.wr   = is_read;
			sd_buf.addr = buf_addr_t'(a);
			sd_buf.data = word;
			bk_q1       = mem_word(1'b0, full);
			bk_q2       = mem_word(1'b1, full);
			#2;
			check_bit("busy during transfer", 1'b1, busy);
			check_bit("loading during transfer", is_read, loading);
			if (is_read) begin
				exp_bank.addr = full;
				exp_bank.wr   = 1'b1;
				exp_bank.data = word;
				if (lba >= 32'h100) begin
					check_bank("load beat on player 2 port", exp_bank, bk2);
					check_bit("player 1 port idle", 1'b0, bk1.wr);
				end else begin
					check_bank("load beat on player 1 port", exp_bank, bk1);
					check_bit("player 2 port idle", 1'b0, bk2.wr);
				end
			end else begin
				check_word("save data to host", mem_word(lba >= 32'h100, full), sd_buf_din);
			end
		end
		tick();
		sd_buf     = '0;
		expect_lba = expect_lba + 1;
	endtask

	initial begin : host_model
		sd_buf = '0;
		bk_q1  = '0;
		bk_q2  = '0;
		forever begin
			tick();
			if (sd_req.rd | sd_req.wr)
				serve_sector();
		end
	end

	task automatic wait_until_idle();
		do
			tick();
		while (busy);
	endtask

	initial begin : clock_gen
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles with tests unfinished", WATCHDOG_CYCLES);
		stop_on_error();
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin : stimulus
		int          i;
		logic [24:0] row;
		palette_t    pal_model;
		reset        = 1'b1;
		xfer         = '0;
		xfer_index   = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		has_save     = 1'b0;
		osd_open     = 1'b0;
		autosave     = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		cram_wr      = '0;
		joy1         = '0;
		joy2         = '0;
		sel1         = '0;
		sel2         = '0;
		audio_mode   = AUDIO_P1;
		core1_audio  = '0;
		core2_audio  = '0;
		expect_read  = 1'b0;
		expect_lba   = '0;
		repeat (3) tick();
		reset = 1'b0;

		pal_model = `GB_PAL_RESET;
		check_palette("palette after reset", pal_model, palette);
		check_bit("read request after reset", 1'b0, sd_req.rd);
		check_bit("write request after reset", 1'b0, sd_req.wr);
		check_bit("busy after reset", 1'b0, busy);
		check_bit("loading after reset", 1'b0, loading);
		check_bit("pending after reset", 1'b0, pending);
		check_bit("save_ok after reset", 1'b0, save_ok);

		// Palette shifts only under the palette index
		for (i = 0; i < PAL_ROWS; i++) begin
			row           = PAL_TAB[i];
			xfer_index    = row[24:17];
			xfer.download = 1'b1;
			xfer.wr       = 1'b1;
			xfer.addr     = 25'(2 * i);
			xfer.data     = row[16:1];
			#2;
			check_bit("bios_download follows index", row[0], bios_download);
			tick();
			xfer = '0;
			if (row[24:17] == `GB_IDX_PALETTE)
				pal_model = (pal_model << 16) | palette_t'({row[8:1], row[16:9]});
			#2;
			check_palette("palette after write", pal_model, palette);
			tick();
		end

		for (i = 0; i < JOY_ROWS; i++) begin
			joy1 = joystick_t'(random_bits(16));
			joy2 = joystick_t'(random_bits(16));
			sel1 = JOY_TAB[i][3:2];
			sel2 = JOY_TAB[i][1:0];
			#2;
			check_nibble("player 1 column", joypad_expect(joy1, sel1), col1);
			check_nibble("player 2 column", joypad_expect(joy2, sel2), col2);
			tick();
		end

		for (i = 0; i < AUD_ROWS; i++) begin
			audio_mode  = AUD_TAB[i];
			core1_audio = stereo_t'(random_bits(32));
			core2_audio = stereo_t'(random_bits(32));
			#2;
			check_stereo("audio output", audio_expect(audio_mode, core1_audio, core2_audio),
				audio);
			tick();
		end

		// Automatic load after a cartridge download
		img_mounted   = 1'b1;
		img_size      = 64'h8000;
		has_save      = 1'b1;
		expect_read   = 1'b1;
		expect_lba    = '0;
		xfer_index    = `GB_IDX_CART_GBC;
		xfer.download = 1'b1;
		repeat (4) tick();
		check_bit("save_ok during download", 1'b1, save_ok);
		xfer.download = 1'b0;
		tick();
		check_bit("no read one edge after download", 1'b0, sd_req.rd);
		tick();
		check_bit("read two edges after download", 1'b1, sd_req.rd);
		check_bit("busy at load start", 1'b1, busy);
		check_bit("loading at load start", 1'b1, loading);
		wait_until_idle();
		check_sector("sectors loaded", 32'h200, expect_lba);
		check_bit("loading after load", 1'b0, loading);

		// Cartridge RAM write then autosave on menu open
		check_bit("pending before RAM write", 1'b0, pending);
		cram_wr = 2'b10;
		tick();
		cram_wr = 2'b00;
		check_bit("pending after RAM write", 1'b1, pending);
		expect_read = 1'b0;
		expect_lba  = '0;
		autosave    = 1'b1;
		osd_open    = 1'b1;
		repeat (2) tick();
		check_bit("write request on menu open", 1'b1, sd_req.wr);
		check_bit("loading during save", 1'b0, loading);
		wait_until_idle();
		check_sector("sectors saved", 32'h200, expect_lba);
		check_bit("pending after save", 1'b0, pending);

		// Explicit save without a save-capable cartridge
		osd_open = 1'b0;
		autosave = 1'b0;
		has_save = 1'b0;
		tick();
		check_bit("save_ok without save support", 1'b0, save_ok);
		save_req = 1'b1;
		repeat (3) tick();
		save_req = 1'b0;
		for (i = 0; i < 6; i++) begin
			check_bit("no save while save_ok low", 1'b0, busy);
			check_bit("no write request while save_ok low", 1'b0, sd_req.wr);
			tick();
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- dual_gb_glue.f
+incdir+hw
hw/gb_host_pkg.sv
hw/gb_player_pkg.sv
hw/download_palette.sv
hw/joypad_matrix.sv
hw/audio_select.sv
hw/backup_sequencer.sv
hw/dual_gb_glue.sv
testbench/dual_gb_glue_assert.sv
testbench/dual_gb_glue_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = dual_gb_glue_tb
FILELIST  = dual_gb_glue.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
